/* src/dsp_mac_config.svh */
`ifndef DSP_MAC_CONFIG_SVH
`define DSP_MAC_CONFIG_SVH

// Operand width seen by the multiplier and the APB data bus
`define DSP_DATA_W 32

// Full signed product and accumulator width
`define DSP_ACC_W 64

// APB byte address width
`define DSP_ADDR_W 8

// Pending and completed operation counters, both wrap
`define DSP_PEND_W 8
`endif

/* src/mac_pkg.sv */
package mac_pkg;

	// ==============================
	// Opcodes carried down the pipe
	// ==============================

	// Encoding matches bits 1:0 of the control register write
	typedef enum logic [1:0] {
		MAC_OP_MUL  = 2'd0,  // Load the product
		MAC_OP_MAC  = 2'd1,  // Add the product
		MAC_OP_MSUB = 2'd2,  // Subtract the product
		MAC_OP_CLR  = 2'd3   // Zero the accumulator
	} mac_op_e;

	// Tag that rides along each multiplier stage
	// Keeps the opcode in step with its operands
	typedef struct packed {
		logic    valid;
		mac_op_e op;
	} mac_tag_t;

endpackage

/* src/apb_regs_pkg.sv */
`include "dsp_mac_config.svh"

package apb_regs_pkg;

	// ==============================
	// Register byte offsets
	// ==============================
	typedef enum logic [`DSP_ADDR_W-1:0] {
		REG_OPA    = 8'h00,  // Operand A, read/write
		REG_OPB    = 8'h04,  // Operand B, read/write
		REG_CTRL   = 8'h08,  // Write issues, read gives last opcode
		REG_STATUS = 8'h0C,  // Operations in flight
		REG_ACC_LO = 8'h10,  // Accumulator bits 31:0
		REG_ACC_HI = 8'h14,  // Accumulator bits 63:32
		REG_OPCNT  = 8'h18   // Completed operations
	} reg_addr_e;

	// Anything else on the bus answers with PSLVERR

endpackage

/* src/dsp_smul_32.sv */
`include "dsp_mac_config.svh"

module dsp_smul_32 (
	input  logic                    CLK,
	input  logic                    rst_n_i,
	input  logic                    valid_i,
	input  mac_pkg::mac_op_e        op_i,
	input  logic [`DSP_DATA_W-1:0]  a_i,
	input  logic [`DSP_DATA_W-1:0]  b_i,
	output logic                    valid_o,
	output mac_pkg::mac_op_e        op_o,
	output logic [`DSP_ACC_W-1:0]   p_o
);

	// Stage one operand registers, signed for the product
	logic signed [`DSP_DATA_W-1:0] a_q;
	logic signed [`DSP_DATA_W-1:0] b_q;
	mac_pkg::mac_tag_t             s1_tag;
	mac_pkg::mac_tag_t             s2_tag;
	// Both operands signed, so the 64 bit context sign-extends them
	logic signed [`DSP_ACC_W-1:0]  prod;

	assign prod = a_q * b_q;

	// ==============================
	// Stage one: operands and tag
	// ==============================
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			a_q    <= '0;
			b_q    <= '0;
			s1_tag <= '{valid: 1'b0, op: mac_pkg::MAC_OP_MUL};
		end else begin
			// Operands hold between issues to save toggling
			if (valid_i) begin
				a_q <= a_i;
				b_q <= b_i;
			end
			s1_tag <= '{valid: valid_i, op: op_i};
		end
	end

	// ==============================
	// Stage two: full product
	// ==============================
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			p_o    <= '0;
			s2_tag <= '{valid: 1'b0, op: mac_pkg::MAC_OP_MUL};
		end else begin
			p_o    <= prod;
			s2_tag <= s1_tag;
		end
	end

	assign valid_o = s2_tag.valid;
	assign op_o    = s2_tag.op;

	// An issued operation always has a defined opcode
	a_op_known: assert property (@(posedge CLK) disable iff (!rst_n_i)
		valid_i |-> !$isunknown(op_i));

endmodule

/* src/dsp_smac_32.sv */
`include "dsp_mac_config.svh"

module dsp_smac_32 (
	input  logic                    CLK,
	input  logic                    rst_n_i,
	input  logic                    op_valid_i,
	input  mac_pkg::mac_op_e        op_code_i,
	input  logic [`DSP_DATA_W-1:0]  op_a_i,
	input  logic [`DSP_DATA_W-1:0]  op_b_i,
	output logic [`DSP_ACC_W-1:0]   acc_o,
	output logic                    done_o,
	output logic [`DSP_PEND_W-1:0]  op_count_o
);

	// Multiplier result side
	logic                   mul_valid;
	mac_pkg::mac_op_e       mul_op;
	logic [`DSP_ACC_W-1:0]  mul_p;

	// ==============================
	// Two-stage signed multiplier
	// ==============================
	dsp_smul_32 u_smul (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.valid_i (op_valid_i),
		.op_i    (op_code_i),
		.a_i     (op_a_i),
		.b_i     (op_b_i),
		.valid_o (mul_valid),
		.op_o    (mul_op),
		.p_o     (mul_p)
	);

	// ==============================
	// Accumulator stage
	// ==============================
	// CLR passes through the multiplier too
	// so it lands in issue order behind earlier MACs
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_o <= '0;
		end else if (mul_valid) begin
			unique case (mul_op)
				mac_pkg::MAC_OP_MUL:  acc_o <= mul_p;
				// Two's complement wrap, no saturation
				mac_pkg::MAC_OP_MAC:  acc_o <= acc_o + mul_p;
				mac_pkg::MAC_OP_MSUB: acc_o <= acc_o - mul_p;
				mac_pkg::MAC_OP_CLR:  acc_o <= '0;
				default:              acc_o <= acc_o;
			endcase
		end
	end

	// Completion pulse, same edge as the accumulator update
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= mul_valid;
		end
	end

	// Completed operations, wraps at 2^DSP_PEND_W
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			op_count_o <= '0;
		end else if (mul_valid) begin
			op_count_o <= op_count_o + 1'b1;
		end
	end

	// Fixed latency: every issue completes three cycles later, nothing else does
	a_done_lat: assert property (@(posedge CLK) disable iff (!rst_n_i)
		done_o == $past(op_valid_i, 3));

endmodule

/* src/dsp_apb_regs.sv */
`include "dsp_mac_config.svh"

module dsp_apb_regs (
	input  logic                    CLK,
	input  logic                    rst_n_i,
	input  logic [`DSP_ADDR_W-1:0]  paddr_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [`DSP_DATA_W-1:0]  pwdata_i,
	output logic [`DSP_DATA_W-1:0]  prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o,
	output logic                    op_valid_o,
	output mac_pkg::mac_op_e        op_code_o,
	output logic [`DSP_DATA_W-1:0]  op_a_o,
	output logic [`DSP_DATA_W-1:0]  op_b_o,
	input  logic [`DSP_ACC_W-1:0]   acc_i,
	input  logic                    done_i,
	input  logic [`DSP_PEND_W-1:0]  op_count_i
);

	// Access cycle of any transfer
	logic                   access;
	// Offset decode
	logic                   addr_hit;
	logic                   addr_ro;
	// Qualified writes, only when no error
	logic                   wr_en;
	logic                   wr_ctrl;
	// Operations issued but not yet done
	logic [`DSP_PEND_W-1:0] pend_cnt;

	assign access = psel_i & penable_i;

	// ==============================
	// Address decode
	// ==============================
	always_comb begin
		addr_hit = 1'b1;
		addr_ro  = 1'b0;
		case (paddr_i)
			apb_regs_pkg::REG_OPA,
			apb_regs_pkg::REG_OPB,
			apb_regs_pkg::REG_CTRL:   addr_ro = 1'b0;
			apb_regs_pkg::REG_STATUS,
			apb_regs_pkg::REG_ACC_LO,
			apb_regs_pkg::REG_ACC_HI,
			apb_regs_pkg::REG_OPCNT:  addr_ro = 1'b1;
			// Unaligned or out of range
			default:                  addr_hit = 1'b0;
		endcase
	end

	// No wait states
	assign pready_o  = 1'b1;
	assign pslverr_o = access & (!addr_hit | (pwrite_i & addr_ro));

	assign wr_en   = access & pwrite_i & !pslverr_o;
	assign wr_ctrl = wr_en & (paddr_i == apb_regs_pkg::REG_CTRL);

	// ==============================
	// Writable registers and issue
	// ==============================
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			op_a_o    <= '0;
			op_b_o    <= '0;
			op_code_o <= mac_pkg::MAC_OP_MUL;
		end else if (wr_en) begin
			if (paddr_i == apb_regs_pkg::REG_OPA)
				op_a_o <= pwdata_i;
			if (paddr_i == apb_regs_pkg::REG_OPB)
				op_b_o <= pwdata_i;
			// Opcode also kept for readback
			if (wr_ctrl)
				op_code_o <= mac_pkg::mac_op_e'(pwdata_i[1:0]);
		end
	end

	// Issue pulse one cycle after the control access cycle
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			op_valid_o <= 1'b0;
		end else begin
			op_valid_o <= wr_ctrl;
		end
	end

	// Pending count, issue and done together cancel
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_cnt <= '0;
		end else begin
			case ({op_valid_o, done_i})
				2'b10:   pend_cnt <= pend_cnt + 1'b1;
				2'b01:   pend_cnt <= pend_cnt - 1'b1;
				default: pend_cnt <= pend_cnt;
			endcase
		end
	end

	// ==============================
	// Read mux
	// ==============================
	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			apb_regs_pkg::REG_OPA:    prdata_o = op_a_o;
			apb_regs_pkg::REG_OPB:    prdata_o = op_b_o;
			apb_regs_pkg::REG_CTRL:   prdata_o = {{(`DSP_DATA_W-2){1'b0}}, op_code_o};
			apb_regs_pkg::REG_STATUS: prdata_o = {{(`DSP_DATA_W-`DSP_PEND_W){1'b0}}, pend_cnt};
			apb_regs_pkg::REG_ACC_LO: prdata_o = acc_i[`DSP_DATA_W-1:0];
			apb_regs_pkg::REG_ACC_HI: prdata_o = acc_i[`DSP_ACC_W-1:`DSP_DATA_W];
			apb_regs_pkg::REG_OPCNT:  prdata_o = {{(`DSP_DATA_W-`DSP_PEND_W){1'b0}}, op_count_i};
			default:                  prdata_o = '0;
		endcase
	end

	// Host follows the APB setup then access order
	a_apb_setup: assert property (@(posedge CLK) disable iff (!rst_n_i)
		$rose(penable_i) |-> $past(psel_i & !penable_i));

	// A completion never arrives without a matching issue
	a_pend_nonzero: assert property (@(posedge CLK) disable iff (!rst_n_i)
		done_i |-> pend_cnt != '0);

endmodule

/* src/dsp_mac_top.sv */
`include "dsp_mac_config.svh"

module dsp_mac_top (
	input  logic                    CLK,
	input  logic                    rst_n_i,
	input  logic [`DSP_ADDR_W-1:0]  paddr_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [`DSP_DATA_W-1:0]  pwdata_i,
	output logic [`DSP_DATA_W-1:0]  prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o
);

	// ==============================
	// Register block to MAC
	// ==============================
	logic                   op_valid;
	mac_pkg::mac_op_e       op_code;
	logic [`DSP_DATA_W-1:0] op_a;
	logic [`DSP_DATA_W-1:0] op_b;
	// MAC results back to the register block
	logic [`DSP_ACC_W-1:0]  acc;
	logic                   done;
	logic [`DSP_PEND_W-1:0] op_count;

	dsp_apb_regs u_regs (
		.CLK        (CLK),
		.rst_n_i    (rst_n_i),
		.paddr_i    (paddr_i),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.op_valid_o (op_valid),
		.op_code_o  (op_code),
		.op_a_o     (op_a),
		.op_b_o     (op_b),
		.acc_i      (acc),
		.done_i     (done),
		.op_count_i (op_count)
	);

	// Always accepts, no handshake back
	dsp_smac_32 u_smac (
		.CLK        (CLK),
		.rst_n_i    (rst_n_i),
		.op_valid_i (op_valid),
		.op_code_i  (op_code),
		.op_a_i     (op_a),
		.op_b_i     (op_b),
		.acc_o      (acc),
		.done_o     (done),
		.op_count_o (op_count)
	);

endmodule

/* tb/tb_dsp_mac.sv */
`include "dsp_mac_config.svh"

module tb_dsp_mac;

	// ==============================
	// Run length and watchdog
	// ==============================
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS    = 5;
	// Counting test issues the most, about 260 control writes
	localparam int OPS_PER_TEST = 260;
	localparam int POLL_LIMIT   = 200;
	localparam longint TIMEOUT  = NUM_TESTS * OPS_PER_TEST * 20 * CLK_PERIOD
		+ (RESET_CYCLES + 200) * CLK_PERIOD;

	logic                   CLK;
	logic                   rst_n;
	logic [`DSP_ADDR_W-1:0] paddr;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`DSP_DATA_W-1:0] pwdata;
	logic [`DSP_DATA_W-1:0] prdata;
	logic                   pready;
	logic                   pslverr;
	// PSLVERR seen in the last access cycle
	logic                   last_err;
	// Reference accumulator and the operands the DUT holds
	logic [63:0]            model_acc;
	logic [31:0]            cur_a;
	logic [31:0]            cur_b;
	logic [31:0]            rd;
	logic [63:0]            acc;
	int                     ctrl_writes;
	int                     n_checks;
	int                     n_errors;
	integer                 seed;

	dsp_mac_top DUT (
		.CLK       (CLK),
		.rst_n_i   (rst_n),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	// ==============================
	// APB transfers
	// ==============================
	// Setup then access, sampled mid access cycle since pready is tied high
	task automatic apb_xfer(input logic wr, input logic [`DSP_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		paddr   = addr;
		pwdata  = wdata;
		pwrite  = wr;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge CLK);
		#2 penable = 1'b1;
		@(negedge CLK);
		rdata    = prdata;
		last_err = pslverr;
		@(posedge CLK);
		#2;
		// Idle unless the next transfer starts right away
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [`DSP_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [`DSP_ADDR_W-1:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'h0, data);
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		int          polls;
		polls  = 0;
		status = 32'hFFFF_FFFF;
		while (status != 0 && polls < POLL_LIMIT) begin
			apb_read(apb_regs_pkg::REG_STATUS, status);
			polls++;
		end
		if (status != 0) begin
			n_errors++;
			$display("Pending count still %0d after %0d status polls", status, polls);
		end
	endtask

	// ==============================
	// Reference model and issue
	// ==============================
	task automatic model_apply(input mac_pkg::mac_op_e op);
		logic signed [63:0] prod;
		// Sign-extend both operands, keep the full 64 bit product
		prod = $signed({{32{cur_a[31]}}, cur_a}) * $signed({{32{cur_b[31]}}, cur_b});
		case (op)
			mac_pkg::MAC_OP_MUL:  model_acc = prod;
			mac_pkg::MAC_OP_MAC:  model_acc = model_acc + prod;
			mac_pkg::MAC_OP_MSUB: model_acc = model_acc - prod;
			default:              model_acc = 64'h0;
		endcase
	endtask

	// Control write only, reuses the operands already in the DUT
	task automatic issue_ctrl(input mac_pkg::mac_op_e op);
		apb_write(apb_regs_pkg::REG_CTRL, {30'd0, op});
		model_apply(op);
		ctrl_writes++;
	endtask

	task automatic issue_op(input mac_pkg::mac_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		apb_write(apb_regs_pkg::REG_OPA, a);
		apb_write(apb_regs_pkg::REG_OPB, b);
		cur_a = a;
		cur_b = b;
		issue_ctrl(op);
	endtask

	task automatic compare_acc(input string name);
		logic [31:0] lo;
		logic [31:0] hi;
		wait_idle();
		apb_read(apb_regs_pkg::REG_ACC_LO, lo);
		apb_read(apb_regs_pkg::REG_ACC_HI, hi);
		acc = {hi, lo};
		check(name, acc, model_acc);
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic test_reset_regs();
		logic [31:0] val;
		apb_read(apb_regs_pkg::REG_ACC_LO, rd);
		check("ACC_LO after reset", rd, 0);
		apb_read(apb_regs_pkg::REG_ACC_HI, rd);
		check("ACC_HI after reset", rd, 0);
		apb_read(apb_regs_pkg::REG_OPCNT, rd);
		check("OPCNT after reset", rd, 0);
		apb_read(apb_regs_pkg::REG_STATUS, rd);
		check("STATUS after reset", rd, 0);
		check("pready_o", pready, 1);
		apb_write(apb_regs_pkg::REG_OPA, 32'hA5A5_0F0F);
		apb_read(apb_regs_pkg::REG_OPA, rd);
		check("OPA readback", rd, 32'hA5A5_0F0F);
		check("pslverr_o on OPA", last_err, 0);
		val = $random(seed);
		apb_write(apb_regs_pkg::REG_OPB, val);
		apb_read(apb_regs_pkg::REG_OPB, rd);
		check("OPB readback", rd, val);
		// Unmapped offset, then a write to a read-only register
		apb_read(8'h1C, rd);
		check("pslverr_o unmapped", last_err, 1);
		apb_write(apb_regs_pkg::REG_ACC_LO, 32'hDEAD_BEEF);
		check("pslverr_o ACC_LO write", last_err, 1);
		apb_read(apb_regs_pkg::REG_ACC_LO, rd);
		check("ACC_LO after bad write", rd, 0);
	endtask

	task automatic test_mul_corners();
		issue_op(mac_pkg::MAC_OP_MUL, -32'sd7, -32'sd123456);
		compare_acc("ACC neg x neg");
		issue_op(mac_pkg::MAC_OP_MUL, 32'h8000_0000, 32'h8000_0000);
		compare_acc("ACC min x min");
		// (-2^31)^2 is 2^62
		check("ACC min x min const", acc, 64'h4000_0000_0000_0000);
		issue_op(mac_pkg::MAC_OP_MUL, 32'h0, $random(seed));
		compare_acc("ACC zero x rand");
	endtask

	task automatic test_dot_product();
		issue_ctrl(mac_pkg::MAC_OP_CLR);
		for (int i = 0; i < 16; i++)
			issue_op(mac_pkg::MAC_OP_MAC, $random(seed), $random(seed));
		// Back to back control writes overlap in the pipeline
		repeat (3) issue_ctrl(mac_pkg::MAC_OP_MAC);
		apb_read(apb_regs_pkg::REG_STATUS, rd);
		check("STATUS ops in flight", rd != 0, 1);
		compare_acc("ACC dot product");
	endtask

	task automatic test_msub_clr();
		issue_op(mac_pkg::MAC_OP_MUL, $random(seed), $random(seed));
		issue_op(mac_pkg::MAC_OP_MSUB, $random(seed), $random(seed));
		issue_op(mac_pkg::MAC_OP_MAC, $random(seed), $random(seed));
		// CLR right behind the MAC must land last
		issue_ctrl(mac_pkg::MAC_OP_CLR);
		compare_acc("ACC after CLR");
		check("ACC zero after CLR", acc, 0);
		issue_op(mac_pkg::MAC_OP_MSUB, $random(seed), $random(seed));
		issue_op(mac_pkg::MAC_OP_MAC, $random(seed), $random(seed));
		issue_op(mac_pkg::MAC_OP_MSUB, 32'h7FFF_FFFF, 32'h8000_0000);
		compare_acc("ACC mixed MSUB");
	endtask

	task automatic test_counting();
		wait_idle();
		apb_read(apb_regs_pkg::REG_OPCNT, rd);
		check("OPCNT", rd, ctrl_writes % 256);
		// Push the completed count past its wrap
		while (ctrl_writes < 280)
			issue_ctrl(mac_pkg::MAC_OP_CLR);
		issue_op(mac_pkg::MAC_OP_MSUB, $random(seed), $random(seed));
		compare_acc("ACC after wrap");
		apb_read(apb_regs_pkg::REG_STATUS, rd);
		check("STATUS idle", rd, 0);
		apb_read(apb_regs_pkg::REG_OPCNT, rd);
		check("OPCNT wrapped", rd, ctrl_writes % 256);
		apb_read(apb_regs_pkg::REG_CTRL, rd);
		check("CTRL last opcode", rd, mac_pkg::MAC_OP_MSUB);
	endtask

	initial begin
		seed        = 81429;
		rst_n       = 1'b0;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		model_acc   = 64'h0;
		cur_a       = 32'h0;
		cur_b       = 32'h0;
		ctrl_writes = 0;
		n_checks    = 0;
		n_errors    = 0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2 rst_n = 1'b1;
		@(posedge CLK);
		#2;
		test_reset_regs();
		test_mul_corners();
		test_dot_product();
		test_msub_clr();
		test_counting();
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT);
		$display("Watchdog expired after %0d time units, run stopped", TIMEOUT);
		$display("Test failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+src
src/mac_pkg.sv
src/apb_regs_pkg.sv
src/dsp_smul_32.sv
src/dsp_smac_32.sv
src/dsp_apb_regs.sv
src/dsp_mac_top.sv
tb/tb_dsp_mac.sv

/* Makefile */
TOP := tb_dsp_mac

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module dsp_mac_top

clean:
	rm -rf obj_dir sim.log
